//--- hdl/idxPkg.sv
// Shared widths, instruction-table fields, flag positions, ALU op codes and decoder controls.
package idxPkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;
    localparam int ITABLE_W = 8;
    localparam int XPT_W = 4;

    // Instruction-table fields.
    localparam int ITB_GROUP = 5;
    localparam int ITB_IY = 4;
    localparam int ITB_OP_MSB = 2;
    localparam int ITB_OP_LSB = 0;
    localparam logic [ITABLE_W-1:0] ITB_LEGAL_MASK = 8'b1100_1000;
    localparam logic [2:0] ITB_OP_ILLEGAL = 3'd7;

    // Bit positions in the flag register.
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_PV = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    // Bit positions in the S Z H PV N C flag write mask.
    localparam int FW_S = 5;
    localparam int FW_Z = 4;
    localparam int FW_H = 3;
    localparam int FW_PV = 2;
    localparam int FW_N = 1;
    localparam int FW_C = 0;
    localparam logic [5:0] FW_ALL = 6'b111111;
    localparam logic [5:0] FW_NO_C = 6'b111110;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_ADC = 4'd1,
        ALU_SUB = 4'd2,
        ALU_SBC = 4'd3,
        ALU_AND = 4'd4,
        ALU_XOR = 4'd5,
        ALU_OR  = 4'd6,
        ALU_INC = 4'd8,
        ALU_DEC = 4'd9
    } aluOpT;

    typedef struct packed {
        logic selIy;
        logic memRd;
        logic memWr;
        logic latchDt;
        logic writeA;
        logic [5:0] flagWrite;
        aluOpT aluOp;
        logic pvIsParity;
        logic resetXpt;
        logic setCm1;
    } ctrlT;

endpackage

//--- hdl/aluGroupDecoder.sv
// Leaf decoder for ALU A,(IX+d)/(IY+d); finishes in one phase.
`timescale 1ns/100ps

module aluGroupDecoder (
    input  logic enable,
    input  logic [idxPkg::XPT_W-1:0] xpt,
    input  logic [idxPkg::ITABLE_W-1:0] itable,
    output idxPkg::ctrlT ctrl
);

    logic [2:0] op;

    assign op = itable[idxPkg::ITB_OP_MSB:idxPkg::ITB_OP_LSB];

    always_comb begin
        ctrl = '0;
        if (enable) begin
            case (xpt)
                0: begin
                    // Read operand, compute and store in one step.
                    ctrl.memRd = 1'b1;
                    ctrl.writeA = 1'b1;
                    ctrl.flagWrite = idxPkg::FW_ALL;
                    ctrl.aluOp = idxPkg::aluOpT'({1'b0, op});
                    ctrl.pvIsParity = (op == 3'(idxPkg::ALU_AND))
                        || (op == 3'(idxPkg::ALU_XOR))
                        || (op == 3'(idxPkg::ALU_OR));
                    ctrl.setCm1 = 1'b1;
                    ctrl.resetXpt = 1'b1;
                end
                default: begin
                    ctrl = '0;
                end
            endcase
        end
    end

endmodule

//--- hdl/incDecGroupDecoder.sv
// Leaf decoder for INC/DEC (IX+d)/(IY+d); read, modify, write over three phases.
`timescale 1ns/100ps

module incDecGroupDecoder (
    input  logic enable,
    input  logic [idxPkg::XPT_W-1:0] xpt,
    input  logic [idxPkg::ITABLE_W-1:0] itable,
    output idxPkg::ctrlT ctrl
);

    logic isDec;

    // Bit 0 of the op field picks the direction.
    assign isDec = itable[idxPkg::ITB_OP_LSB];

    always_comb begin
        ctrl = '0;
        if (enable) begin
            case (xpt)
                0: begin
                    ctrl.memRd = 1'b1;
                    ctrl.latchDt = 1'b1;
                end
                1: begin
                    // Carry is left untouched.
                    ctrl.aluOp = isDec ? idxPkg::ALU_DEC : idxPkg::ALU_INC;
                    ctrl.flagWrite = idxPkg::FW_NO_C;
                end
                2: begin
                    ctrl.memWr = 1'b1;
                    ctrl.setCm1 = 1'b1;
                    ctrl.resetXpt = 1'b1;
                end
                default: begin
                    ctrl = '0;
                end
            endcase
        end
    end

endmodule

//--- hdl/indexedGroupDecoder.sv
// Branch decoder for the 11xx1 indexed group; enables one leaf and merges the controls.
`timescale 1ns/100ps

module indexedGroupDecoder (
    input  logic enable,
    input  logic [idxPkg::XPT_W-1:0] xpt,
    input  logic [idxPkg::ITABLE_W-1:0] itable,
    output idxPkg::ctrlT ctrl,
    output logic legal
);

    logic baseEn;
    logic aluEn;
    logic incDecEn;
    idxPkg::ctrlT aluCtrl;
    idxPkg::ctrlT incDecCtrl;

    assign legal = ((itable & idxPkg::ITB_LEGAL_MASK) == idxPkg::ITB_LEGAL_MASK)
        && (itable[idxPkg::ITB_OP_MSB:idxPkg::ITB_OP_LSB] != idxPkg::ITB_OP_ILLEGAL);

    assign baseEn = enable && legal;
    assign aluEn = baseEn && !itable[idxPkg::ITB_GROUP];
    assign incDecEn = baseEn && itable[idxPkg::ITB_GROUP];

    aluGroupDecoder aluDec0 (
        .enable(aluEn),
        .xpt(xpt),
        .itable(itable),
        .ctrl(aluCtrl)
    );

    incDecGroupDecoder incDecDec0 (
        .enable(incDecEn),
        .xpt(xpt),
        .itable(itable),
        .ctrl(incDecCtrl)
    );

    // Disabled leaf drives zero, so OR merges cleanly.
    always_comb begin
        ctrl = idxPkg::ctrlT'(aluCtrl | incDecCtrl);
        ctrl.selIy = baseEn && itable[idxPkg::ITB_IY];
    end

    leafCtrlExclusive: assert #0 (!((aluCtrl != '0) && (incDecCtrl != '0)))
        else $error("both leaf decoders driving controls");

endmodule

//--- hdl/phaseSequencer.sv
// Phase sequencer that accepts an instruction, steps xpt and holds operands until it ends.
`timescale 1ns/100ps

module phaseSequencer (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic [idxPkg::ITABLE_W-1:0] itable,
    input  logic [idxPkg::DATA_W-1:0] disp,
    input  idxPkg::ctrlT ctrl,
    input  logic [idxPkg::DATA_W-1:0] memRdData,
    input  logic legal,
    output logic [idxPkg::XPT_W-1:0] xpt,
    output logic [idxPkg::ITABLE_W-1:0] itableQ,
    output logic [idxPkg::DATA_W-1:0] dispQ,
    output logic [idxPkg::DATA_W-1:0] dtQ,
    output logic busy,
    output logic done,
    output logic illegal
);

    logic accept;

    // Start is ignored while an instruction runs.
    assign accept = start && !busy;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= 1'b0;
            xpt <= '0;
            done <= 1'b0;
            illegal <= 1'b0;
        end else begin
            done <= ctrl.setCm1;
            illegal <= busy && !legal;
            if (accept) begin
                busy <= 1'b1;
                xpt <= '0;
            end else if (busy) begin
                if (ctrl.resetXpt || !legal) begin
                    busy <= 1'b0;
                    xpt <= '0;
                end else begin
                    xpt <= xpt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            itableQ <= itable;
            dispQ <= disp;
        end
        // Memory operand for read-modify-write.
        if (ctrl.latchDt) begin
            dtQ <= memRdData;
        end
    end

    // An instruction ends either normally or as illegal, never both.
    doneIllegalExclusive: assert property (
        @(posedge clk) disable iff (!rstN) !(done && illegal)
    ) else $error("done and illegal high together");

endmodule

//--- hdl/indexedAlu.sv
// 8-bit ALU with accumulator and flags, plus the (index + d) address adder.
`timescale 1ns/100ps

module indexedAlu (
    input  logic clk,
    input  logic rstN,
    input  idxPkg::ctrlT ctrl,
    input  logic [idxPkg::ADDR_W-1:0] ix,
    input  logic [idxPkg::ADDR_W-1:0] iy,
    input  logic [idxPkg::DATA_W-1:0] dispQ,
    input  logic [idxPkg::DATA_W-1:0] dtQ,
    input  logic [idxPkg::DATA_W-1:0] memRdData,
    output logic [idxPkg::ADDR_W-1:0] memAddr,
    output logic [idxPkg::DATA_W-1:0] memWrData,
    output logic [idxPkg::DATA_W-1:0] a,
    output logic [idxPkg::DATA_W-1:0] flags
);

    logic [idxPkg::ADDR_W-1:0] indexSel;
    logic [idxPkg::ADDR_W-1:0] effAddr;
    logic isIncDec;
    logic isLogic;
    logic isSub;
    logic carryIn;
    logic [idxPkg::DATA_W-1:0] opA;
    logic [idxPkg::DATA_W-1:0] opB;
    logic [idxPkg::DATA_W-1:0] opBEff;
    logic [idxPkg::DATA_W:0] arith;
    logic [4:0] halfArith;
    logic [idxPkg::DATA_W-1:0] result;
    logic [idxPkg::DATA_W-1:0] newFlags;
    logic [idxPkg::DATA_W-1:0] writeMask;

    assign indexSel = ctrl.selIy ? iy : ix;
    assign effAddr = indexSel
        + {{(idxPkg::ADDR_W - idxPkg::DATA_W){dispQ[idxPkg::DATA_W-1]}}, dispQ};
    assign memAddr = (ctrl.memRd || ctrl.memWr) ? effAddr : '0;

    always_comb begin
        isIncDec = (ctrl.aluOp == idxPkg::ALU_INC) || (ctrl.aluOp == idxPkg::ALU_DEC);
        isLogic = (ctrl.aluOp == idxPkg::ALU_AND) || (ctrl.aluOp == idxPkg::ALU_XOR)
            || (ctrl.aluOp == idxPkg::ALU_OR);
        isSub = (ctrl.aluOp == idxPkg::ALU_SUB) || (ctrl.aluOp == idxPkg::ALU_SBC)
            || (ctrl.aluOp == idxPkg::ALU_DEC);
        carryIn = ((ctrl.aluOp == idxPkg::ALU_ADC) || (ctrl.aluOp == idxPkg::ALU_SBC))
            && flags[idxPkg::FLAG_C];

        // INC/DEC work on the latched operand against one.
        opA = isIncDec ? dtQ : a;
        opB = isIncDec ? {{(idxPkg::DATA_W-1){1'b0}}, 1'b1} : memRdData;
        opBEff = isSub ? ~opB : opB;

        if (isSub) begin
            arith = {1'b0, opA} - {1'b0, opB} - carryIn;
            halfArith = {1'b0, opA[3:0]} - {1'b0, opB[3:0]} - carryIn;
        end else begin
            arith = {1'b0, opA} + {1'b0, opB} + carryIn;
            halfArith = {1'b0, opA[3:0]} + {1'b0, opB[3:0]} + carryIn;
        end

        case (ctrl.aluOp)
            idxPkg::ALU_AND: result = opA & opB;
            idxPkg::ALU_XOR: result = opA ^ opB;
            idxPkg::ALU_OR:  result = opA | opB;
            default:         result = arith[idxPkg::DATA_W-1:0];
        endcase

        newFlags = '0;
        newFlags[idxPkg::FLAG_S] = result[idxPkg::DATA_W-1];
        newFlags[idxPkg::FLAG_Z] = (result == '0);
        newFlags[idxPkg::FLAG_H] = isLogic ? (ctrl.aluOp == idxPkg::ALU_AND) : halfArith[4];
        // Parity is even parity, overflow is signed.
        newFlags[idxPkg::FLAG_PV] = ctrl.pvIsParity ? ~^result
            : (opA[idxPkg::DATA_W-1] == opBEff[idxPkg::DATA_W-1])
              && (result[idxPkg::DATA_W-1] != opA[idxPkg::DATA_W-1]);
        newFlags[idxPkg::FLAG_N] = isSub;
        newFlags[idxPkg::FLAG_C] = !isLogic && arith[idxPkg::DATA_W];

        writeMask = '0;
        writeMask[idxPkg::FLAG_S] = ctrl.flagWrite[idxPkg::FW_S];
        writeMask[idxPkg::FLAG_Z] = ctrl.flagWrite[idxPkg::FW_Z];
        writeMask[idxPkg::FLAG_H] = ctrl.flagWrite[idxPkg::FW_H];
        writeMask[idxPkg::FLAG_PV] = ctrl.flagWrite[idxPkg::FW_PV];
        writeMask[idxPkg::FLAG_N] = ctrl.flagWrite[idxPkg::FW_N];
        writeMask[idxPkg::FLAG_C] = ctrl.flagWrite[idxPkg::FW_C];
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            a <= '0;
            flags <= '0;
        end else begin
            if (ctrl.writeA) begin
                a <= result;
            end
            flags <= (flags & ~writeMask) | (newFlags & writeMask);
        end
    end

    // Result held for the write-back phase.
    always_ff @(posedge clk) begin
        if (isIncDec) begin
            memWrData <= result;
        end
    end

    memStrobeExclusive: assert property (
        @(posedge clk) disable iff (!rstN) !(ctrl.memRd && ctrl.memWr)
    ) else $error("memRd and memWr high together");

endmodule

//--- hdl/indexedExecTop.sv
// Top level of the indexed-memory executor; connect to a zero-latency memory and the index registers.
`timescale 1ns/100ps

module indexedExecTop (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic [idxPkg::ITABLE_W-1:0] itable,
    input  logic [idxPkg::DATA_W-1:0] disp,
    input  logic [idxPkg::ADDR_W-1:0] ix,
    input  logic [idxPkg::ADDR_W-1:0] iy,
    input  logic [idxPkg::DATA_W-1:0] memRdData,
    output logic [idxPkg::ADDR_W-1:0] memAddr,
    output logic [idxPkg::DATA_W-1:0] memWrData,
    output logic memRd,
    output logic memWr,
    output logic busy,
    output logic done,
    output logic illegal,
    output logic [idxPkg::DATA_W-1:0] a,
    output logic [idxPkg::DATA_W-1:0] flags
);

    idxPkg::ctrlT ctrl;
    logic legal;
    logic [idxPkg::XPT_W-1:0] xpt;
    logic [idxPkg::ITABLE_W-1:0] itableQ;
    logic [idxPkg::DATA_W-1:0] dispQ;
    logic [idxPkg::DATA_W-1:0] dtQ;

    assign memRd = ctrl.memRd;
    assign memWr = ctrl.memWr;

    phaseSequencer seq0 (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .itable(itable),
        .disp(disp),
        .ctrl(ctrl),
        .memRdData(memRdData),
        .legal(legal),
        .xpt(xpt),
        .itableQ(itableQ),
        .dispQ(dispQ),
        .dtQ(dtQ),
        .busy(busy),
        .done(done),
        .illegal(illegal)
    );

    // Decoder runs only while an instruction is in flight.
    indexedGroupDecoder dec0 (
        .enable(busy),
        .xpt(xpt),
        .itable(itableQ),
        .ctrl(ctrl),
        .legal(legal)
    );

    indexedAlu alu0 (
        .clk(clk),
        .rstN(rstN),
        .ctrl(ctrl),
        .ix(ix),
        .iy(iy),
        .dispQ(dispQ),
        .dtQ(dtQ),
        .memRdData(memRdData),
        .memAddr(memAddr),
        .memWrData(memWrData),
        .a(a),
        .flags(flags)
    );

endmodule

//--- verif/indexedExecModel.svh
// Reference model of accumulator, flag and memory results for inclusion in the testbench module.
`ifndef INDEXED_EXEC_MODEL_SVH
`define INDEXED_EXEC_MODEL_SVH

typedef struct packed {
    logic [7:0] res;
    logic [7:0] flags;
} modelOutT;

// Bits 7, 6 and 3 set, and op field not 7.
function automatic logic isLegalItable(input logic [7:0] itb);
    return itb[7] && itb[6] && itb[3] && (itb[2:0] != 3'd7);
endfunction

function automatic modelOutT modelAluOp(input logic [2:0] op, input logic [7:0] acc,
        input logic [7:0] flagsIn, input logic [7:0] operand);
    modelOutT result;
    int cin;
    int full;
    int low;
    int ones;
    result.flags = flagsIn;
    cin = (op == 3'd1 || op == 3'd3) ? flagsIn[idxPkg::FLAG_C] : 0;
    if (op <= 3'd1) begin
        full = acc + operand + cin;
        low = acc % 16 + operand % 16 + cin;
        result.res = full[7:0];
        result.flags[idxPkg::FLAG_H] = low > 15;
        result.flags[idxPkg::FLAG_PV] = (acc[7] == operand[7]) && (result.res[7] != acc[7]);
        result.flags[idxPkg::FLAG_C] = full > 255;
    end else if (op <= 3'd3) begin
        full = acc - operand - cin;
        low = acc % 16 - operand % 16 - cin;
        result.res = full[7:0];
        result.flags[idxPkg::FLAG_H] = low < 0;
        result.flags[idxPkg::FLAG_PV] = (acc[7] != operand[7]) && (result.res[7] != acc[7]);
        result.flags[idxPkg::FLAG_C] = full < 0;
    end else begin
        case (op)
            3'd4: result.res = acc & operand;
            3'd5: result.res = acc ^ operand;
            default: result.res = acc | operand;
        endcase
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            ones += result.res[i];
        end
        // Logic ops set H only for AND and PV to even parity.
        result.flags[idxPkg::FLAG_H] = op == 3'd4;
        result.flags[idxPkg::FLAG_PV] = (ones % 2) == 0;
        result.flags[idxPkg::FLAG_C] = 1'b0;
    end
    result.flags[idxPkg::FLAG_N] = (op == 3'd2) || (op == 3'd3);
    result.flags[idxPkg::FLAG_S] = result.res[7];
    result.flags[idxPkg::FLAG_Z] = result.res == 8'h00;
    return result;
endfunction

// Carry is kept from flagsIn.
function automatic modelOutT modelIncDec(input logic isDec, input logic [7:0] value,
        input logic [7:0] flagsIn);
    modelOutT result;
    result.flags = flagsIn;
    if (isDec) begin
        result.res = value - 8'd1;
        result.flags[idxPkg::FLAG_H] = value[3:0] == 4'h0;
        result.flags[idxPkg::FLAG_PV] = value == 8'h80;
    end else begin
        result.res = value + 8'd1;
        result.flags[idxPkg::FLAG_H] = value[3:0] == 4'hf;
        result.flags[idxPkg::FLAG_PV] = value == 8'h7f;
    end
    result.flags[idxPkg::FLAG_N] = isDec;
    result.flags[idxPkg::FLAG_S] = result.res[7];
    result.flags[idxPkg::FLAG_Z] = result.res == 8'h00;
    return result;
endfunction

`endif

//--- verif/indexedExecTb.sv
// Testbench that runs random ALU, INC/DEC and illegal instructions against a reference model.
`timescale 1ns/100ps

module indexedExecTb;

    localparam int NUM_ALU = 300;
    localparam int NUM_INC_DEC = 150;
    localparam int NUM_ILLEGAL = 50;
    localparam int TIMEOUT_CYCLES = (NUM_ALU + NUM_INC_DEC + NUM_ILLEGAL) * 6 + 50;

    logic clk;
    logic rstN;
    logic start;
    logic [7:0] itable;
    logic [7:0] disp;
    logic [15:0] ix;
    logic [15:0] iy;
    logic [7:0] memRdData;
    logic [15:0] memAddr;
    logic [7:0] memWrData;
    logic memRd;
    logic memWr;
    logic busy;
    logic done;
    logic illegal;
    logic [7:0] a;
    logic [7:0] flags;

    logic [7:0] mem [0:255];
    logic [7:0] modelMem [0:255];
    logic [7:0] expA;
    logic [7:0] expFlags;
    logic [31:0] lcgState;
    int cycleCount = 0;

    `include "indexedExecModel.svh"

    indexedExecTop dut0 (.*);

    always #2 clk = ~clk;

    // Zero-latency memory.
    assign memRdData = memRd ? mem[memAddr[7:0]] : 8'h00;

    always @(posedge clk) begin
        if (memWr) begin
            mem[memAddr[7:0]] <= memWrData;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    function automatic logic [15:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15];
    endfunction

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Either clears one of bits 7, 6, 3 or keeps the pattern with op 7.
    function automatic logic [7:0] makeIllegalItable(input logic [15:0] r);
        logic [7:0] itb;
        itb = r[15:8];
        case (r[2:1])
            2'd0: itb[7] = 1'b0;
            2'd1: itb[6] = 1'b0;
            2'd2: itb[3] = 1'b0;
            default: itb = {2'b11, r[9:8], 1'b1, 3'b111};
        endcase
        return itb;
    endfunction

    task automatic runInstr(input logic [7:0] itb, input logic [7:0] d, input logic spurious);
        logic legal;
        logic [15:0] expAddr;
        logic [15:0] junk;
        modelOutT expOut;
        int edges;
        int rdCount;
        int wrCount;
        legal = isLegalItable(itb);
        ix = lcgNext();
        iy = lcgNext();
        itable = itb;
        disp = d;
        start = 1'b1;
        expAddr = (itb[idxPkg::ITB_IY] ? iy : ix) + {{8{d[7]}}, d};
        expOut = {expA, expFlags};
        edges = 0;
        rdCount = 0;
        wrCount = 0;
        do begin
            @(negedge clk);
            edges++;
            if (memRd) begin
                rdCount++;
                checkEq("memAddr", memAddr, expAddr);
                if (itb[idxPkg::ITB_GROUP]) begin
                    expOut = modelIncDec(itb[0], modelMem[expAddr[7:0]], expFlags);
                end else begin
                    expOut = modelAluOp(itb[2:0], expA, expFlags, modelMem[expAddr[7:0]]);
                end
            end
            if (memWr) begin
                wrCount++;
                checkEq("memAddr", memAddr, expAddr);
                checkEq("memWrData", memWrData, expOut.res);
            end
            if (!done && !illegal) begin
                checkEq("busy", busy, 1'b1);
            end
            // Second start while busy that must be ignored.
            junk = lcgNext();
            start = spurious && (edges == 1);
            itable = start ? junk[15:8] : itb;
            disp = start ? junk[7:0] : d;
        end while (!done && !illegal);
        checkEq("done latency", edges - 1, (legal && itb[idxPkg::ITB_GROUP]) ? 3 : 1);
        checkEq("done", done, legal);
        checkEq("illegal", illegal, !legal);
        checkEq("busy", busy, 1'b0);
        checkEq("memRd count", rdCount, legal);
        checkEq("memWr count", wrCount, legal && itb[idxPkg::ITB_GROUP]);
        if (legal) begin
            expFlags = expOut.flags;
            if (itb[idxPkg::ITB_GROUP]) begin
                modelMem[expAddr[7:0]] = expOut.res;
            end else begin
                expA = expOut.res;
            end
        end
        checkEq("a", a, expA);
        checkEq("flags", flags, expFlags);
        checkEq("mem", mem[expAddr[7:0]], modelMem[expAddr[7:0]]);
        @(negedge clk);
        checkEq("done", done, 1'b0);
        checkEq("illegal", illegal, 1'b0);
        checkEq("busy", busy, 1'b0);
    endtask

    initial begin
        int remAlu;
        int remIncDec;
        int remIllegal;
        int pick;
        logic [15:0] r;
        logic [7:0] itb;
        lcgState = 32'd25;
        clk = 1'b0;
        rstN = 1'b0;
        start = 1'b0;
        itable = 8'h00;
        disp = 8'h00;
        ix = 16'h0000;
        iy = 16'h0000;
        expA = 8'h00;
        expFlags = 8'h00;
        for (int i = 0; i < 256; i++) begin
            r = lcgNext();
            mem[i] = r[7:0];
            modelMem[i] = r[7:0];
        end
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkEq("a", a, 8'h00);
        checkEq("flags", flags, 8'h00);
        checkEq("busy", busy, 1'b0);
        checkEq("done", done, 1'b0);
        checkEq("illegal", illegal, 1'b0);
        checkEq("memRd", memRd, 1'b0);
        checkEq("memWr", memWr, 1'b0);
        remAlu = NUM_ALU;
        remIncDec = NUM_INC_DEC;
        remIllegal = NUM_ILLEGAL;
        while (remAlu + remIncDec + remIllegal > 0) begin
            r = lcgNext();
            pick = r % (remAlu + remIncDec + remIllegal);
            if (pick < remAlu) begin
                itb = {2'b11, 1'b0, r[0], 1'b1, 3'(r[10:8] % 7)};
                remAlu--;
            end else if (pick < remAlu + remIncDec) begin
                itb = {2'b11, 1'b1, r[0], 1'b1, 3'(r[10:8] % 7)};
                remIncDec--;
            end else begin
                itb = makeIllegalItable(r);
                remIllegal--;
            end
            r = lcgNext();
            runInstr(itb, r[7:0], r[9:8] == 2'b00);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+verif
hdl/idxPkg.sv
hdl/aluGroupDecoder.sv
hdl/incDecGroupDecoder.sv
hdl/indexedGroupDecoder.sv
hdl/phaseSequencer.sv
hdl/indexedAlu.sv
hdl/indexedExecTop.sv
verif/indexedExecTb.sv

//--- Bender.yml
package:
  name: indexed_exec

sources:
  - hdl/idxPkg.sv
  - hdl/aluGroupDecoder.sv
  - hdl/incDecGroupDecoder.sv
  - hdl/indexedGroupDecoder.sv
  - hdl/phaseSequencer.sv
  - hdl/indexedAlu.sv
  - hdl/indexedExecTop.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/indexedExecTb.sv
